// File: design/tbre_pkg.sv
// shared definitions for the tag revocation sweeper
// register map, tagged word width and the capability word view
package tbre_pkg;

  // tagged word, tag sits in the top bit
  localparam int unsigned TagW = 33;

  // register byte offsets on the wishbone port
  localparam logic [7:0] RegStart  = 8'h00;
  localparam logic [7:0] RegEnd    = 8'h04;
  localparam logic [7:0] RegCtrl   = 8'h08;
  localparam logic [7:0] RegStatus = 8'h0C;
  localparam logic [7:0] RegBitmap = 8'h10;

  // one data word seen either as plain data or as a capability
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [2:0]  perm;
      logic [28:0] addr8;
    } cap;
  } cap_word_u;

endpackage

// File: design/tbre_regs.sv
// wishbone classic register block for the sweeper
// holds the range, kick, busy/done status and the revocation bitmap
module tbre_regs #(
  parameter int unsigned RevokeWords = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [7:0]                wb_adr_i,
  input  logic [31:0]               wb_dat_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  input  logic                      tbre_done_i,
  output logic [31:0]               start_addr_o,
  output logic [31:0]               end_addr_o,
  output logic                      kick_o,
  output logic [RevokeWords*32-1:0] bitmap_o
);

  logic                      wb_req;
  logic                      ack_q;
  logic                      busy_q;
  logic                      done_q;
  logic [31:0]               start_q;
  logic [31:0]               end_q;
  logic                      kick_q;
  logic [RevokeWords*32-1:0] bitmap_q;
  logic [31:0]               rdata_d;
  logic [31:0]               rdata_q;

  // new access only while ack is low, so each access acks once
  assign wb_req = wb_cyc_i & wb_stb_i & ~ack_q;

  always_comb begin
    rdata_d = '0;
    case (wb_adr_i)
      tbre_pkg::RegStart:  rdata_d = start_q;
      tbre_pkg::RegEnd:    rdata_d = end_q;
      tbre_pkg::RegCtrl:   rdata_d = {31'd0, kick_q};
      tbre_pkg::RegStatus: rdata_d = {30'd0, done_q, busy_q};
      default: ;
    endcase
    for (int i = 0; i < RevokeWords; i++) begin
      if (wb_adr_i == tbre_pkg::RegBitmap + 8'(4 * i)) begin
        rdata_d = bitmap_q[32*i +: 32];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      start_q  <= '0;
      end_q    <= '0;
      kick_q   <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      bitmap_q <= '0;
    end else begin
      ack_q <= wb_req;
      if (wb_req && wb_we_i) begin
        if (wb_adr_i == tbre_pkg::RegStart) start_q <= wb_dat_i;
        if (wb_adr_i == tbre_pkg::RegEnd) end_q <= wb_dat_i;
        if (wb_adr_i == tbre_pkg::RegCtrl) begin
          kick_q <= wb_dat_i[0];
          // a kick starts a new sweep and drops the old done flag
          if (wb_dat_i[0]) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
          end
        end
        for (int i = 0; i < RevokeWords; i++) begin
          if (wb_adr_i == tbre_pkg::RegBitmap + 8'(4 * i)) begin
            bitmap_q[32*i +: 32] <= wb_dat_i;
          end
        end
      end
      if (tbre_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_req) rdata_q <= rdata_d;
  end

  assign wb_ack_o     = ack_q;
  assign wb_dat_o     = rdata_q;
  assign start_addr_o = start_q;
  assign end_addr_o   = end_q;
  assign kick_o       = kick_q;
  assign bitmap_o     = bitmap_q;

  // the master keeps cyc and stb up until it has seen the ack
  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

// File: design/tbre_engine.sv
// tag revocation sweep engine
// loads the low word of each granule and stores it back untagged when revoked
module tbre_engine #(
  parameter int unsigned FifoSize = 4,
  parameter int unsigned AddrHi   = 11
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [64:0]               tbre_ctrl_vec_i,
  output logic                      tbre_done_o,
  input  logic                      lsu_tbre_resp_valid_i,
  input  logic                      lsu_tbre_resp_err_i,
  input  logic                      lsu_tbre_resp_is_wr_i,
  input  logic [tbre_pkg::TagW-1:0] lsu_tbre_raw_lsw_i,
  input  logic                      lsu_tbre_req_done_i,
  input  logic                      lsu_tbre_addr_incr_i,
  output logic                      tbre_lsu_req_o,
  output logic                      tbre_lsu_is_cap_o,
  output logic                      tbre_lsu_we_o,
  output logic [31:0]               tbre_lsu_addr_o,
  output logic [tbre_pkg::TagW-1:0] tbre_lsu_wdata_o,
  input  logic                      snoop_lsu_req_done_i,
  input  logic                      snoop_lsu_req_i,
  input  logic                      snoop_lsu_is_cap_i,
  input  logic                      snoop_lsu_we_i,
  input  logic                      snoop_lsu_cheri_err_i,
  input  logic [31:0]               snoop_lsu_addr_i,
  input  logic                      trvk_en_i,
  input  logic                      trvk_clrtag_i
);

  localparam int unsigned FifoPtrW = $clog2(FifoSize);
  localparam logic [1:0] FsmIdle  = 2'd0;
  localparam logic [1:0] FsmLoad  = 2'd1;
  localparam logic [1:0] FsmWait  = 2'd2;
  localparam logic [1:0] SchNone  = 2'd0;
  localparam logic [1:0] SchLoad  = 2'd1;
  localparam logic [1:0] SchStore = 2'd2;

  logic              kick, kick_q, kick_rise;
  logic [31:0]       start_addr, end_addr, load_addr, store_addr;
  logic [1:0]        fsm_q, fsm_d, sch_q, sch_d;
  logic [AddrHi-3:0] cur_load_addr8, load_addr8_p1;
  logic              load_stop_cond, load_gnt, store_gnt, store_req_valid;
  logic              wait_resp_q, snoop_hit;
  logic              req_fifo_wr_en, cap_fifo_wr_en, shdw_fifo_wr_en, fifo_rd_en;
  logic              fifo_not_empty;
  logic [FifoPtrW:0] req_wr_ptr, cap_wr_ptr, shdw_wr_ptr, rd_ptr, os_req_cnt;

  // entry storage, the three FIFOs share one read pointer
  logic [AddrHi-3:0]             req_addr8_q [FifoSize];
  logic [FifoSize-1:0]           req_vld_q;
  logic [tbre_pkg::TagW:0]       cap_q [FifoSize];
  logic [FifoSize-1:0]           shdw_q;
  logic [AddrHi-3:0]             head_addr8;
  logic [tbre_pkg::TagW:0]       head_cap;

  assign kick       = tbre_ctrl_vec_i[64];
  assign end_addr   = tbre_ctrl_vec_i[63:32];
  assign start_addr = tbre_ctrl_vec_i[31:0];
  assign kick_rise  = kick & ~kick_q;

  assign tbre_done_o = (fsm_q != FsmIdle) && (fsm_d == FsmIdle);

  // address bits above AddrHi come from the start address
  assign load_addr  = {start_addr[31:AddrHi+1], cur_load_addr8, 3'b000};
  assign store_addr = {start_addr[31:AddrHi+1], head_addr8, 3'b000};

  assign tbre_lsu_req_o    = ((sch_q == SchLoad) | ((sch_q == SchStore) & store_req_valid))
                             & ~wait_resp_q;
  assign tbre_lsu_is_cap_o = (sch_q == SchLoad);
  assign tbre_lsu_we_o     = (sch_q == SchStore);
  assign tbre_lsu_addr_o   = (sch_q == SchLoad) ?
                             load_addr + {29'd0, lsu_tbre_addr_incr_i, 2'b00} : store_addr;
  assign tbre_lsu_wdata_o  = {1'b0, head_cap[31:0]};

  assign load_addr8_p1  = cur_load_addr8 + 1'b1;
  assign load_stop_cond = (load_addr8_p1 > end_addr[AddrHi:3]);
  assign load_gnt       = (sch_q == SchLoad) & lsu_tbre_req_done_i;
  assign store_gnt      = (sch_q == SchStore) & lsu_tbre_req_done_i;

  always_comb begin
    logic load_stall;
    logic req_fifo_full;

    load_stall    = (os_req_cnt >= FifoSize - 1);
    req_fifo_full = (os_req_cnt >= FifoSize);

    // walk progress
    fsm_d = fsm_q;
    if ((fsm_q == FsmIdle) && kick_rise) fsm_d = FsmLoad;
    else if ((fsm_q == FsmLoad) && load_gnt && load_stop_cond) fsm_d = FsmWait;
    else if ((fsm_q == FsmWait) && (os_req_cnt == 0)) fsm_d = FsmIdle;

    // alternate loads and invalidation stores
    sch_d = sch_q;
    case (sch_q)
      SchNone: begin
        if ((fsm_q == FsmLoad) && !req_fifo_full) sch_d = SchLoad;
        else if (store_req_valid) sch_d = SchStore;
      end
      SchLoad: begin
        if (load_gnt && (load_stall || (fsm_d == FsmWait))) begin
          sch_d = store_req_valid ? SchStore : SchNone;
        end
      end
      SchStore: begin
        if (store_gnt) sch_d = (fsm_q == FsmLoad) ? SchLoad : SchNone;
      end
      default: sch_d = SchNone;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kick_q         <= 1'b0;
      fsm_q          <= FsmIdle;
      sch_q          <= SchNone;
      cur_load_addr8 <= '0;
      wait_resp_q    <= 1'b0;
      rd_ptr         <= '0;
      req_wr_ptr     <= '0;
      cap_wr_ptr     <= '0;
      shdw_wr_ptr    <= '0;
    end else begin
      kick_q <= kick;
      fsm_q  <= fsm_d;
      sch_q  <= sch_d;
      if (kick_rise && (fsm_q == FsmIdle)) cur_load_addr8 <= start_addr[AddrHi:3];
      else if (load_gnt) cur_load_addr8 <= load_addr8_p1;
      // one access in flight at a time
      if (load_gnt || store_gnt) wait_resp_q <= 1'b1;
      else if (lsu_tbre_resp_valid_i) wait_resp_q <= 1'b0;
      if (fifo_rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (req_fifo_wr_en) req_wr_ptr <= req_wr_ptr + 1'b1;
      if (cap_fifo_wr_en) cap_wr_ptr <= cap_wr_ptr + 1'b1;
      if (shdw_fifo_wr_en) shdw_wr_ptr <= shdw_wr_ptr + 1'b1;
    end
  end

  // core write to the low word of a queued granule, a high word store leaves it alone
  assign snoop_hit = snoop_lsu_req_i & snoop_lsu_req_done_i & snoop_lsu_we_i
                     & ~snoop_lsu_cheri_err_i & (snoop_lsu_is_cap_i | ~snoop_lsu_addr_i[2])
                     & (snoop_lsu_addr_i[31:AddrHi+1] == start_addr[31:AddrHi+1]);

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < FifoSize; i++) begin
      if (req_fifo_wr_en && (int'(req_wr_ptr[FifoPtrW-1:0]) == i)) begin
        req_addr8_q[i] <= cur_load_addr8;
        req_vld_q[i]   <= 1'b1;
      end else if (snoop_hit && (req_addr8_q[i] == snoop_lsu_addr_i[AddrHi:3])) begin
        req_vld_q[i] <= 1'b0;
      end
    end
    if (cap_fifo_wr_en) begin
      cap_q[cap_wr_ptr[FifoPtrW-1:0]] <= {lsu_tbre_resp_err_i, lsu_tbre_raw_lsw_i};
    end
    if (shdw_fifo_wr_en) shdw_q[shdw_wr_ptr[FifoPtrW-1:0]] <= trvk_clrtag_i;
  end

  assign os_req_cnt = req_wr_ptr - rd_ptr;
  assign head_addr8 = req_addr8_q[rd_ptr[FifoPtrW-1:0]];
  assign head_cap   = cap_q[rd_ptr[FifoPtrW-1:0]];

  assign fifo_not_empty = (req_wr_ptr != rd_ptr) && (cap_wr_ptr != rd_ptr)
                          && (shdw_wr_ptr != rd_ptr);

  // store only a tagged, revoked, error free word that no core write has touched
  assign store_req_valid = fifo_not_empty & head_cap[32] & shdw_q[rd_ptr[FifoPtrW-1:0]]
                           & req_vld_q[rd_ptr[FifoPtrW-1:0]] & ~head_cap[33];

  assign fifo_rd_en      = fifo_not_empty & (store_gnt | ~store_req_valid);
  assign req_fifo_wr_en  = load_gnt;
  assign cap_fifo_wr_en  = lsu_tbre_resp_valid_i & ~lsu_tbre_resp_is_wr_i;
  assign shdw_fifo_wr_en = trvk_en_i;

  a_no_idle_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tbre_lsu_req_o && (fsm_q == FsmIdle) && !fifo_not_empty));

  a_os_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    os_req_cnt <= FifoSize);

endmodule

// File: design/revoke_checker.sv
// revocation checker
// looks up the granule a returned capability points to in the bitmap
module revoke_checker #(
  parameter int unsigned RevokeWords = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      resp_valid_i,
  input  logic                      resp_is_wr_i,
  input  logic [tbre_pkg::TagW-1:0] resp_data_i,
  input  logic [RevokeWords*32-1:0] bitmap_i,
  output logic                      trvk_en_o,
  output logic                      trvk_clrtag_o
);

  localparam int unsigned IdxW = $clog2(RevokeWords * 32);

  tbre_pkg::cap_word_u cap_w;

  assign cap_w.raw = resp_data_i[31:0];

  // one shadow bit per load response, in load order
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trvk_en_o <= 1'b0;
    end else begin
      trvk_en_o <= resp_valid_i & ~resp_is_wr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    trvk_clrtag_o <= resp_data_i[32] & bitmap_i[cap_w.cap.addr8[IdxW-1:0]];
  end

endmodule

// File: design/lsu_arbiter.sv
// memory arbiter between the core port and the sweep engine
// core has priority, responses are routed back to the granted side
module lsu_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      cpu_req_i,
  input  logic                      cpu_we_i,
  input  logic [31:0]               cpu_addr_i,
  input  logic [tbre_pkg::TagW-1:0] cpu_wdata_i,
  output logic                      cpu_done_o,
  output logic                      cpu_rvalid_o,
  output logic [tbre_pkg::TagW-1:0] cpu_rdata_o,
  input  logic                      eng_req_i,
  input  logic                      eng_we_i,
  input  logic                      eng_is_cap_i,
  input  logic [31:0]               eng_addr_i,
  input  logic [tbre_pkg::TagW-1:0] eng_wdata_i,
  output logic                      eng_done_o,
  output logic                      eng_resp_valid_o,
  output logic                      eng_resp_is_wr_o,
  output logic                      eng_resp_err_o,
  output logic [tbre_pkg::TagW-1:0] eng_rdata_o,
  output logic                      snoop_req_o,
  output logic                      snoop_done_o,
  output logic                      snoop_we_o,
  output logic [31:0]               snoop_addr_o,
  output logic                      mem_en_o,
  output logic                      mem_we_o,
  output logic [31:0]               mem_addr_o,
  output logic [tbre_pkg::TagW-1:0] mem_wdata_o,
  input  logic [tbre_pkg::TagW-1:0] mem_rdata_i,
  input  logic                      mem_err_i
);

  logic cpu_rsp_q;
  logic eng_rsp_q;
  logic eng_wr_q;
  logic [31:0] eng_addr;

  assign cpu_done_o = cpu_req_i;
  assign eng_done_o = eng_req_i & ~cpu_req_i;

  // capability accesses start at the granule base
  assign eng_addr = eng_is_cap_i ? {eng_addr_i[31:3], 3'b000} : eng_addr_i;

  assign mem_en_o    = cpu_req_i | eng_req_i;
  assign mem_we_o    = cpu_req_i ? cpu_we_i : eng_we_i;
  assign mem_addr_o  = cpu_req_i ? cpu_addr_i : eng_addr;
  assign mem_wdata_o = cpu_req_i ? cpu_wdata_i : eng_wdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cpu_rsp_q <= 1'b0;
      eng_rsp_q <= 1'b0;
      eng_wr_q  <= 1'b0;
    end else begin
      cpu_rsp_q <= cpu_done_o;
      eng_rsp_q <= eng_done_o;
      eng_wr_q  <= eng_done_o & eng_we_i;
    end
  end

  assign cpu_rvalid_o     = cpu_rsp_q;
  assign cpu_rdata_o      = mem_rdata_i;
  assign eng_resp_valid_o = eng_rsp_q;
  assign eng_resp_is_wr_o = eng_wr_q;
  assign eng_resp_err_o   = mem_err_i;
  assign eng_rdata_o      = mem_rdata_i;

  // every core access is visible to the engine
  assign snoop_req_o  = cpu_req_i;
  assign snoop_done_o = cpu_done_o;
  assign snoop_we_o   = cpu_we_i;
  assign snoop_addr_o = cpu_addr_i;

  // the engine waits for each response before it asks again
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    eng_done_o |=> !eng_req_i);

endmodule

// File: design/tagged_mem.sv
// word memory with one tag bit per 32-bit word
// registered read data, out of range accesses only flag an error
module tagged_mem #(
  parameter int unsigned AddrHi = 11
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      we_i,
  input  logic [31:0]               addr_i,
  input  logic [tbre_pkg::TagW-1:0] wdata_i,
  output logic [tbre_pkg::TagW-1:0] rdata_o,
  output logic                      err_o
);

  localparam int unsigned Words = 2 ** (AddrHi - 1);

  logic [tbre_pkg::TagW-1:0] mem_q [Words];
  logic                      oob;

  assign oob = |addr_i[31:AddrHi+1];

  always_ff @(posedge clk_i) begin
    if (en_i && !oob) begin
      if (we_i) mem_q[addr_i[AddrHi:2]] <= wdata_i;
      rdata_o <= mem_q[addr_i[AddrHi:2]];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o <= 1'b0;
    end else begin
      err_o <= en_i & oob;
    end
  end

endmodule

// File: design/tbre_top.sv
// tag revocation sweeper subsystem
// registers, engine, checker, arbiter and tagged memory
module tbre_top #(
  parameter int unsigned FifoSize    = 4,
  parameter int unsigned AddrHi      = 11,
  parameter int unsigned RevokeWords = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [7:0]                wb_adr_i,
  input  logic [31:0]               wb_dat_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  input  logic                      cpu_req_i,
  input  logic                      cpu_we_i,
  input  logic [31:0]               cpu_addr_i,
  input  logic [tbre_pkg::TagW-1:0] cpu_wdata_i,
  output logic                      cpu_done_o,
  output logic                      cpu_rvalid_o,
  output logic [tbre_pkg::TagW-1:0] cpu_rdata_o
);

  logic [31:0]               start_addr, end_addr, eng_addr, snoop_addr, mem_addr;
  logic                      kick, tbre_done, trvk_en, trvk_clrtag;
  logic [RevokeWords*32-1:0] bitmap;
  logic                      eng_req, eng_we, eng_is_cap, eng_done;
  logic                      resp_valid, resp_is_wr, resp_err;
  logic [tbre_pkg::TagW-1:0] eng_wdata, resp_data, mem_wdata, mem_rdata;
  logic                      snoop_req, snoop_done, snoop_we;
  logic                      mem_en, mem_we, mem_err;

  tbre_regs #(.RevokeWords(RevokeWords)) u_regs (
    .clk_i, .rst_ni, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o,
    .tbre_done_i(tbre_done), .start_addr_o(start_addr), .end_addr_o(end_addr),
    .kick_o(kick), .bitmap_o(bitmap)
  );

  tbre_engine #(.FifoSize(FifoSize), .AddrHi(AddrHi)) u_engine (
    .clk_i, .rst_ni,
    .tbre_ctrl_vec_i({kick, end_addr, start_addr}), .tbre_done_o(tbre_done),
    .lsu_tbre_resp_valid_i(resp_valid), .lsu_tbre_resp_err_i(resp_err),
    .lsu_tbre_resp_is_wr_i(resp_is_wr), .lsu_tbre_raw_lsw_i(resp_data),
    .lsu_tbre_req_done_i(eng_done), .lsu_tbre_addr_incr_i(1'b0),
    .tbre_lsu_req_o(eng_req), .tbre_lsu_is_cap_o(eng_is_cap), .tbre_lsu_we_o(eng_we),
    .tbre_lsu_addr_o(eng_addr), .tbre_lsu_wdata_o(eng_wdata),
    .snoop_lsu_req_done_i(snoop_done), .snoop_lsu_req_i(snoop_req),
    .snoop_lsu_is_cap_i(1'b0), .snoop_lsu_we_i(snoop_we),
    .snoop_lsu_cheri_err_i(1'b0), .snoop_lsu_addr_i(snoop_addr),
    .trvk_en_i(trvk_en), .trvk_clrtag_i(trvk_clrtag)
  );

  revoke_checker #(.RevokeWords(RevokeWords)) u_checker (
    .clk_i, .rst_ni, .resp_valid_i(resp_valid), .resp_is_wr_i(resp_is_wr),
    .resp_data_i(resp_data), .bitmap_i(bitmap),
    .trvk_en_o(trvk_en), .trvk_clrtag_o(trvk_clrtag)
  );

  lsu_arbiter u_arbiter (
    .clk_i, .rst_ni,
    .cpu_req_i, .cpu_we_i, .cpu_addr_i, .cpu_wdata_i, .cpu_done_o, .cpu_rvalid_o, .cpu_rdata_o,
    .eng_req_i(eng_req), .eng_we_i(eng_we), .eng_is_cap_i(eng_is_cap),
    .eng_addr_i(eng_addr), .eng_wdata_i(eng_wdata), .eng_done_o(eng_done),
    .eng_resp_valid_o(resp_valid), .eng_resp_is_wr_o(resp_is_wr),
    .eng_resp_err_o(resp_err), .eng_rdata_o(resp_data),
    .snoop_req_o(snoop_req), .snoop_done_o(snoop_done), .snoop_we_o(snoop_we),
    .snoop_addr_o(snoop_addr),
    .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata), .mem_err_i(mem_err)
  );

  tagged_mem #(.AddrHi(AddrHi)) u_mem (
    .clk_i, .rst_ni, .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .rdata_o(mem_rdata), .err_o(mem_err)
  );

endmodule

// File: tb/tbre_tb.sv
// testbench for the tag revocation sweeper
// directed register, sweep and core traffic tests against a memory model
module tbre_tb;

  localparam int unsigned BusTimeout  = 20;
  localparam int unsigned DoneTimeout = 400;
  localparam int unsigned PollTimeout = 200;
  localparam int          RevokedIdx [5] = '{3, 10, 17, 40, 63};
  localparam int          NotRevoked = 5;

  logic                      clk;
  logic                      rst_n;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [7:0]                wb_adr;
  logic [31:0]               wb_dat_w;
  logic [31:0]               wb_dat_r;
  logic                      wb_ack;
  logic                      cpu_req;
  logic                      cpu_we;
  logic [31:0]               cpu_addr;
  logic [tbre_pkg::TagW-1:0] cpu_wdata;
  logic [tbre_pkg::TagW-1:0] cpu_rdata;
  logic                      cpu_done;
  logic                      cpu_rvalid;

  // expected memory contents and bitmap
  logic [tbre_pkg::TagW-1:0] model_mem [1024];
  logic [63:0]               bitmap_model;
  integer                    seed;
  int                        errors;
  int                        checks;

  tbre_top #(.FifoSize(4), .AddrHi(11), .RevokeWords(2)) dut (
    .clk_i(clk), .rst_ni(rst_n),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
    .cpu_req_i(cpu_req), .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
    .cpu_done_o(cpu_done), .cpu_rvalid_o(cpu_rvalid), .cpu_rdata_o(cpu_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("checks: %0d  errors: %0d", checks, errors + 1);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_word(input string name, input logic [tbre_pkg::TagW-1:0] got,
                            input logic [tbre_pkg::TagW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] wb_dat_o %s: got %h expected %h", name, got, exp);
    end
  endtask

  // handshake latency in cycles after the request
  task automatic verify_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("%s came %0d cycles after the request instead of %0d", name, got, exp);
    end
  endtask

  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int cycles;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    cycles   = 0;
    @(negedge clk);
    while (!wb_ack) begin
      cycles++;
      if (cycles > BusTimeout) abort_run("register port never acknowledged the access");
      @(negedge clk);
    end
    verify_latency("wb_ack_o", cycles, 1);
    rdat = wb_dat_r;
    // the transfer completes on the edge where ack is high
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'h0, dat);
  endtask

  task automatic cpu_access(input logic we, input logic [31:0] addr,
                            input logic [tbre_pkg::TagW-1:0] wdata,
                            output logic [tbre_pkg::TagW-1:0] rdata);
    int cycles;
    @(posedge clk);
    #1;
    cpu_req   = 1'b1;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cycles    = 0;
    @(negedge clk);
    while (!cpu_done) begin
      cycles++;
      if (cycles > BusTimeout) abort_run("core port never signalled done");
      @(negedge clk);
    end
    verify_latency("cpu_done_o", cycles, 0);
    @(posedge clk);
    #1;
    cpu_req = 1'b0;
    cpu_we  = 1'b0;
    rdata   = '0;
    if (!we) begin
      cycles = 0;
      @(negedge clk);
      while (!cpu_rvalid) begin
        cycles++;
        if (cycles > BusTimeout) abort_run("core port never returned read data");
        @(negedge clk);
      end
      verify_latency("cpu_rvalid_o", cycles, 0);
      rdata = cpu_rdata;
    end
  endtask

  // core writes always land in the model
  task automatic cpu_write(input logic [31:0] addr, input logic [tbre_pkg::TagW-1:0] data);
    logic [tbre_pkg::TagW-1:0] unused;
    cpu_access(1'b1, addr, data, unused);
    model_mem[addr[11:2]] = data;
  endtask

  task automatic cpu_read(input logic [31:0] addr, output logic [tbre_pkg::TagW-1:0] data);
    cpu_access(1'b0, addr, '0, data);
  endtask

  task automatic expect_mem(input logic [31:0] addr);
    logic [tbre_pkg::TagW-1:0] rd;
    cpu_read(addr, rd);
    check_word($sformatf("cpu_rdata_o at %h", addr), rd, model_mem[addr[11:2]]);
  endtask

  task automatic scan_region(input logic [31:0] first, input logic [31:0] last);
    for (logic [31:0] a = first; a <= last + 32'd4; a += 32'd4) expect_mem(a);
  endtask

  function automatic logic [31:0] make_cap(input logic [2:0] perm, input logic [28:0] addr8);
    tbre_pkg::cap_word_u cw;
    cw.cap.perm  = perm;
    cw.cap.addr8 = addr8;
    return cw.raw;
  endfunction

  // a tagged granule low word whose addr8 bit is set in the bitmap loses its tag
  task automatic predict_sweep(input logic [31:0] first, input logic [31:0] last);
    tbre_pkg::cap_word_u cw;
    int idx;
    for (int g = int'(first[11:3]); g <= int'(last[11:3]); g++) begin
      idx    = 2 * g;
      cw.raw = model_mem[idx][31:0];
      if (model_mem[idx][32] && bitmap_model[cw.cap.addr8[5:0]]) model_mem[idx][32] = 1'b0;
    end
  endtask

  task automatic write_bitmap();
    wb_write(tbre_pkg::RegBitmap, bitmap_model[31:0]);
    wb_write(tbre_pkg::RegBitmap + 8'd4, bitmap_model[63:32]);
  endtask

  task automatic run_sweep(input logic [31:0] first, input logic [31:0] last);
    wb_write(tbre_pkg::RegStart, first);
    wb_write(tbre_pkg::RegEnd, last);
    predict_sweep(first, last);
    wb_write(tbre_pkg::RegCtrl, 32'h1);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int polls;
    polls = 0;
    wb_read(tbre_pkg::RegStatus, st);
    while (!st[1]) begin
      polls++;
      if (polls > DoneTimeout) abort_run("sweep did not finish in time");
      wb_read(tbre_pkg::RegStatus, st);
    end
    check_reg("status", st, 32'h2);
    wb_write(tbre_pkg::RegCtrl, 32'h0);
  endtask

  // one random core access, a live capability into a low word or any access to a high word
  task automatic core_noise(input logic [31:0] first, input int unsigned granules,
                            input logic [31:0] keep);
    logic [31:0] pick;
    logic [31:0] addr;
    pick = $random(seed);
    addr = first + 32'(8 * (pick[15:2] % granules));
    // a low word write may land between the engine's load and its store
    if (pick[1] && (addr != keep)) begin
      cpu_write(addr, {1'b1, make_cap(3'b011, {23'(pick[31:16]), 6'(NotRevoked)})});
    end else if (pick[0]) begin
      cpu_write(addr + 32'd4, {1'b1, make_cap(3'b111, 29'($random(seed)))});
    end else begin
      expect_mem(addr + 32'd4);
    end
  endtask

  task automatic register_readback();
    logic [31:0] rd;
    wb_read(tbre_pkg::RegStatus, rd);
    check_reg("status", rd, 32'h0);
    wb_read(tbre_pkg::RegCtrl, rd);
    check_reg("ctrl", rd, 32'h0);
    wb_write(tbre_pkg::RegStart, 32'h0000_0120);
    wb_write(tbre_pkg::RegEnd, 32'h0000_0ff8);
    wb_write(tbre_pkg::RegBitmap, 32'hdead_beef);
    wb_write(tbre_pkg::RegBitmap + 8'd4, 32'h1234_5678);
    wb_read(tbre_pkg::RegStart, rd);
    check_reg("start", rd, 32'h0000_0120);
    wb_read(tbre_pkg::RegEnd, rd);
    check_reg("end", rd, 32'h0000_0ff8);
    wb_read(tbre_pkg::RegBitmap, rd);
    check_reg("bitmap0", rd, 32'hdead_beef);
    wb_read(tbre_pkg::RegBitmap + 8'd4, rd);
    check_reg("bitmap1", rd, 32'h1234_5678);
    wb_read(tbre_pkg::RegStatus, rd);
    check_reg("status", rd, 32'h0);
  endtask

  // tagged, non revoked, untagged and high words side by side
  task automatic basic_sweep();
    logic [tbre_pkg::TagW-1:0] low;
    int k;
    bitmap_model = '0;
    for (int i = 0; i < 5; i++) bitmap_model[RevokedIdx[i]] = 1'b1;
    write_bitmap();
    for (int g = 0; g < 32; g++) begin
      k = g % 5;
      case (g % 4)
        0, 3: low = {1'b1, make_cap(3'b101, {23'(g), 6'(RevokedIdx[k])})};
        1: low = {1'b1, make_cap(3'b011, {23'(g), 6'(NotRevoked)})};
        default: low = {1'b0, make_cap(3'b001, {23'(g), 6'(RevokedIdx[k])})};
      endcase
      cpu_write(32'(8 * g), low);
      cpu_write(32'(8 * g + 4), {1'b1, make_cap(3'b111, 29'(RevokedIdx[(g + 1) % 5]))});
    end
    run_sweep(32'h0, 32'h0f8);
    wait_done();
    scan_region(32'h0, 32'h0f8);
  endtask

  task automatic repeated_kicks();
    logic [31:0] rd;
    wb_read(tbre_pkg::RegStatus, rd);
    check_reg("status", rd, 32'h2);
    // nothing left to revoke on a second pass
    run_sweep(32'h0, 32'h0f8);
    wait_done();
    scan_region(32'h0, 32'h0f8);
    // kick edge while the walk is running, a restart would revoke granule 0 again
    run_sweep(32'h0, 32'h0f8);
    wb_write(tbre_pkg::RegCtrl, 32'h0);
    cpu_write(32'h0, {1'b1, make_cap(3'b101, 29'(RevokedIdx[0]))});
    wb_write(tbre_pkg::RegCtrl, 32'h1);
    wb_read(tbre_pkg::RegStatus, rd);
    check_reg("status", rd, 32'h1);
    wait_done();
    expect_mem(32'h0);
  endtask

  task automatic core_write_race();
    logic [tbre_pkg::TagW-1:0] tval;
    logic [tbre_pkg::TagW-1:0] rd;
    int polls;
    for (int g = 64; g < 96; g++) begin
      cpu_write(32'(8 * g),
                {1'b1, make_cap(3'b101, {23'(g), 6'((g % 2) ? NotRevoked : RevokedIdx[g % 5])})});
      cpu_write(32'(8 * g + 4), {1'b1, make_cap(3'b110, 29'($random(seed)))});
    end
    tval = model_mem[32'h220 >> 2];
    run_sweep(32'h200, 32'h2f8);
    rd    = tval;
    polls = 0;
    while (rd[32]) begin
      core_noise(32'h200, 32, 32'h220);
      cpu_read(32'h220, rd);
      polls++;
      if (polls > PollTimeout) abort_run("engine never revoked the target granule");
    end
    check_word("cpu_rdata_o at 00000220", rd, {1'b0, tval[31:0]});
    // the core puts the capability back, its write is the later one
    cpu_write(32'h220, tval);
    repeat (8) core_noise(32'h200, 32, 32'h220);
    wait_done();
    scan_region(32'h200, 32'h2f8);
  endtask

  task automatic random_sweep();
    logic [31:0] tag;
    bitmap_model = {32'($random(seed)), 32'($random(seed))};
    write_bitmap();
    for (int a = 32'h400; a < 32'h600; a += 4) begin
      tag = $random(seed);
      cpu_write(a, {tag[0], 32'($random(seed))});
    end
    run_sweep(32'h400, 32'h5f8);
    wait_done();
    scan_region(32'h400, 32'h5f8);
  endtask

  initial begin
    seed      = 32'h14ad;
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    cpu_req   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    register_readback();
    basic_sweep();
    repeated_kicks();
    core_write_race();
    random_sweep();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
design/tbre_pkg.sv
design/tbre_regs.sv
design/tbre_engine.sv
design/revoke_checker.sv
design/lsu_arbiter.sv
design/tagged_mem.sv
design/tbre_top.sv
tb/tbre_tb.sv

// File: run.sh
#!/bin/sh
# build and run the sweeper testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tbre_tb -o tbre_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tbre_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
  echo "no verdict found in sim.log"
  exit 1
fi
exit 0
